/* decode_stage.sv */
// Decode stage with register file, hazard stall, debug read port and the decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic               clk,
	input  logic               rst,
	input  wisc_pkg::word_t    instr,
	input  logic               instr_valid,
	output logic               stall,
	output logic               halting,
	input  logic               dbg_req,
	input  wisc_pkg::reg_idx_t dbg_reg,
	output wisc_pkg::word_t    dbg_data,
	output logic               dbg_ack,
	id_ex_ifc.producer         id_ex,
	ex_mem_ifc.monitor         ex_mem,
	mem_wb_ifc.consumer        mem_wb
);
	import wisc_pkg::*;

	word_t    regs [NUM_REGS];
	opcode_t  op;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	word_t    rd_val;
	word_t    rs_val;
	word_t    rt_val;
	logic     wb_en;
	reg_idx_t wb_dest;
	word_t    wb_data;
	logic     use_rs;
	logic     use_rt;
	logic     use_rd;
	logic     dec_write;
	logic     dec_load;
	logic     dec_store;
	logic     dec_halt;
	alu_op_t  dec_alu;
	word_t    dec_a;
	word_t    dec_b;
	logic     ie_write;
	logic     em_write;
	logic     hazard;
	logic     accept;

	// Register read with same-cycle writeback bypass
	function automatic word_t read_reg(input reg_idx_t idx);
		return (wb_en && wb_dest == idx) ? wb_data : regs[idx];
	endfunction

	function automatic logic dest_hit(input logic wr, input reg_idx_t dest, input reg_idx_t src);
		return wr && (dest == src);
	endfunction

	assign op      = opcode_t'(instr[15:12]);
	assign rd      = instr[11:8];
	assign rs      = instr[7:4];
	assign rt      = instr[3:0];
	assign wb_en   = mem_wb.valid && mem_wb.reg_write && !mem_wb.halt; // HLT never writes
	assign wb_dest = mem_wb.dest;
	assign wb_data = mem_wb.wb_data;
	assign rd_val  = read_reg(rd);
	assign rs_val  = read_reg(rs);
	assign rt_val  = read_reg(rt);

	always_comb begin
		dec_alu   = ALU_PASSB;
		dec_a     = rs_val;
		dec_b     = rt_val;
		dec_write = 1'b0;
		dec_load  = 1'b0;
		dec_store = 1'b0;
		dec_halt  = 1'b0;
		use_rs    = 1'b0;
		use_rt    = 1'b0;
		use_rd    = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
				dec_alu   = alu_op_t'(instr[14:12]);
				dec_write = 1'b1;
				use_rs    = 1'b1;
				use_rt    = 1'b1;
			end
			OP_SLL, OP_SRL, OP_SRA: begin
				dec_alu   = alu_op_t'(instr[14:12]);
				dec_b     = {12'h000, rt}; // Shift amount
				dec_write = 1'b1;
				use_rs    = 1'b1;
			end
			OP_LW, OP_SW: begin
				dec_alu   = ALU_ADD;
				dec_b     = {{12{rt[3]}}, rt}; // Signed word offset
				dec_load  = (op == OP_LW);
				dec_store = (op == OP_SW);
				dec_write = (op == OP_LW);
				use_rs    = 1'b1;
				use_rd    = (op == OP_SW);
			end
			OP_LHB: begin
				dec_a     = rd_val;
				dec_b     = {instr[7:0], 8'h00};
				dec_write = 1'b1;
				use_rd    = 1'b1;
			end
			OP_LLB: begin
				dec_a     = '0;
				dec_b     = {{8{instr[7]}}, instr[7:0]};
				dec_write = 1'b1;
			end
			OP_HLT: dec_halt = 1'b1;
			default: ; // Unused opcodes are no-ops
		endcase
	end

	assign ie_write = id_ex.valid && id_ex.reg_write;
	assign em_write = ex_mem.valid && ex_mem.reg_write;
	assign hazard = (use_rs && (dest_hit(ie_write, id_ex.dest, rs) ||
	                            dest_hit(em_write, ex_mem.dest, rs))) ||
	                (use_rt && (dest_hit(ie_write, id_ex.dest, rt) ||
	                            dest_hit(em_write, ex_mem.dest, rt))) ||
	                (use_rd && (dest_hit(ie_write, id_ex.dest, rd) ||
	                            dest_hit(em_write, ex_mem.dest, rd)));
	assign stall  = instr_valid && !halting && hazard;
	assign accept = instr_valid && !halting && !hazard;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_dest] <= wb_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			halting <= 1'b0;
			dbg_ack <= 1'b0;
		end else begin
			if (accept && dec_halt) begin
				halting <= 1'b1;
			end else if (!instr_valid) begin
				halting <= 1'b0; // Fetch emptied after run fell
			end
			if (dbg_req && !dbg_ack) begin
				dbg_ack <= 1'b1;
			end else if (!dbg_req) begin
				dbg_ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dbg_req && !dbg_ack) begin
			dbg_data <= read_reg(dbg_reg);
		end
	end

	// Control half of the decode/execute register, a bubble on stall
	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.valid     <= 1'b0;
			id_ex.reg_write <= 1'b0;
			id_ex.mem_read  <= 1'b0;
			id_ex.mem_write <= 1'b0;
			id_ex.halt      <= 1'b0;
		end else begin
			id_ex.valid     <= accept;
			id_ex.reg_write <= accept && dec_write;
			id_ex.mem_read  <= accept && dec_load;
			id_ex.mem_write <= accept && dec_store;
			id_ex.halt      <= accept && dec_halt;
		end
	end

	always_ff @(posedge clk) begin
		id_ex.alu_op     <= dec_alu;
		id_ex.operand_a  <= dec_a;
		id_ex.operand_b  <= dec_b;
		id_ex.store_data <= rd_val;
		id_ex.dest       <= rd;
	end

endmodule

`default_nettype wire

/* execute_stage.sv */
// Execute stage with the ALU and the execute/memory register; instantiated in wisc_core
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic        clk,
	input  logic        rst,
	id_ex_ifc.consumer  id_ex,
	ex_mem_ifc.producer ex_mem
);
	import wisc_pkg::*;

	word_t      alu_out;
	logic [3:0] shamt;

	assign shamt = id_ex.operand_b[3:0];

	always_comb begin
		alu_out = id_ex.operand_b;
		case (id_ex.alu_op)
			ALU_ADD: alu_out = id_ex.operand_a + id_ex.operand_b; // Also LW/SW address
			ALU_SUB: alu_out = id_ex.operand_a - id_ex.operand_b;
			ALU_AND: alu_out = id_ex.operand_a & id_ex.operand_b;
			ALU_NOR: alu_out = ~(id_ex.operand_a | id_ex.operand_b);
			ALU_SLL: alu_out = id_ex.operand_a << shamt;
			ALU_SRL: alu_out = id_ex.operand_a >> shamt;
			ALU_SRA: alu_out = word_t'($signed(id_ex.operand_a) >>> shamt);
			// Byte merge; LLB arrives with A cleared
			ALU_PASSB: alu_out = id_ex.operand_b | {8'h00, id_ex.operand_a[7:0]};
			default: alu_out = id_ex.operand_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid     <= 1'b0;
			ex_mem.reg_write <= 1'b0;
			ex_mem.mem_read  <= 1'b0;
			ex_mem.mem_write <= 1'b0;
			ex_mem.halt      <= 1'b0;
		end else begin
			ex_mem.valid     <= id_ex.valid;
			ex_mem.reg_write <= id_ex.reg_write;
			ex_mem.mem_read  <= id_ex.mem_read;
			ex_mem.mem_write <= id_ex.mem_write;
			ex_mem.halt      <= id_ex.halt;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem.result     <= alu_out;
		ex_mem.store_data <= id_ex.store_data; // Passed through for SW
		ex_mem.dest       <= id_ex.dest;
	end

endmodule

`default_nettype wire

/* fetch_stage.sv */
// Fetch stage with PC, loadable instruction memory and the fetch/decode register; used in wisc_core
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic            clk,
	input  logic            rst,
	input  logic            run,
	input  logic            stall,
	input  logic            halting,
	input  logic            load_req,
	input  wisc_pkg::pc_t   load_addr,
	input  wisc_pkg::word_t load_data,
	output logic            load_ack,
	output wisc_pkg::word_t instr,
	output logic            instr_valid
);
	import wisc_pkg::*;

	word_t imem [IMEM_DEPTH];
	pc_t   pc;
	logic  load_accept;
	logic  advance;

	assign load_accept = load_req && !load_ack && !run; // New request, core stopped
	assign advance     = run && !stall && !halting;

	always_ff @(posedge clk) begin
		if (load_accept) begin
			imem[load_addr] <= load_data;
		end
	end

	// Four-phase slave for the load port
	always_ff @(posedge clk) begin
		if (rst) begin
			load_ack <= 1'b0;
		end else if (load_accept) begin
			load_ack <= 1'b1;
		end else if (!load_req) begin
			load_ack <= 1'b0; // Master has released req
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= '0;
			instr_valid <= 1'b0;
		end else if (!run) begin
			pc          <= '0;   // Park at the program start
			instr_valid <= 1'b0;
		end else if (advance) begin
			pc          <= pc + 8'd1;
			instr_valid <= 1'b1;
		end
	end

	// Fetched word, held during a stall or after HLT
	always_ff @(posedge clk) begin
		if (!run) begin
			instr <= NOP_WORD;
		end else if (advance) begin
			instr <= imem[pc];
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
wisc_pkg.sv
pipe_ifc.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
wisc_core.sv
wisc_core_sva.sv
tb_wisc_core.sv

/* memory_stage.sv */
// Memory stage with data memory, writeback select, halt flag and the memory/writeback register
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  logic         clk,
	input  logic         rst,
	ex_mem_ifc.consumer  ex_mem,
	mem_wb_ifc.producer  mem_wb,
	output logic         halt,
	input  logic         run
);
	import wisc_pkg::*;

	word_t  dmem [DMEM_DEPTH];
	daddr_t addr;
	word_t  load_word;

	assign addr      = ex_mem.result[7:0]; // Upper address bits ignored
	assign load_word = dmem[addr];

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.mem_write) begin
			dmem[addr] <= ex_mem.store_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb.valid     <= 1'b0;
			mem_wb.reg_write <= 1'b0;
			mem_wb.halt      <= 1'b0;
			halt             <= 1'b0;
		end else begin
			mem_wb.valid     <= ex_mem.valid;
			mem_wb.reg_write <= ex_mem.reg_write;
			mem_wb.halt      <= ex_mem.halt;
			if (!run) begin
				halt <= 1'b0;
			end else if (ex_mem.valid && ex_mem.halt) begin
				halt <= 1'b1; // Older writes finish on this edge
			end
		end
	end

	always_ff @(posedge clk) begin
		mem_wb.wb_data <= ex_mem.mem_read ? load_word : ex_mem.result;
		mem_wb.dest    <= ex_mem.dest;
	end

endmodule

`default_nettype wire

/* pipe_ifc.sv */
// Pipeline register bundles between decode, execute, memory and writeback; instantiated in wisc_core
`timescale 1ns/1ps
`default_nettype none

interface id_ex_ifc;
	import wisc_pkg::*;

	logic     valid;
	alu_op_t  alu_op;
	word_t    operand_a;
	word_t    operand_b;
	word_t    store_data; // Old rd value, stored by SW
	reg_idx_t dest;
	logic     reg_write;
	logic     mem_read;
	logic     mem_write;
	logic     halt;

	modport producer (output valid, alu_op, operand_a, operand_b, store_data, dest,
		reg_write, mem_read, mem_write, halt);
	modport consumer (input valid, alu_op, operand_a, operand_b, store_data, dest,
		reg_write, mem_read, mem_write, halt);
	modport monitor (input valid, dest, reg_write, halt);
endinterface

interface ex_mem_ifc;
	import wisc_pkg::*;

	logic     valid;
	word_t    result;     // ALU result or data address
	word_t    store_data;
	reg_idx_t dest;
	logic     reg_write;
	logic     mem_read;
	logic     mem_write;
	logic     halt;

	modport producer (output valid, result, store_data, dest, reg_write, mem_read,
		mem_write, halt);
	modport consumer (input valid, result, store_data, dest, reg_write, mem_read,
		mem_write, halt);
	modport monitor (input valid, dest, reg_write);
endinterface

interface mem_wb_ifc;
	import wisc_pkg::*;

	logic     valid;
	word_t    wb_data;
	reg_idx_t dest;
	logic     reg_write;
	logic     halt;

	modport producer (output valid, wb_data, dest, reg_write, halt);
	modport consumer (input valid, wb_data, dest, reg_write, halt);
	modport monitor (input valid, dest, reg_write, halt);
endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status follows the test result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_wisc_core -f filelist.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
	exit 0
else
	exit 1
fi

/* tb_wisc_core.sv */
// Testbench for wisc_core; reads wisc_tests.txt, loads each program, runs it to halt, checks registers
`timescale 1ns/1ps
`default_nettype none

module tb_wisc_core;
	import wisc_pkg::*;

	localparam int CLK_HALF        = 20;
	localparam int HS_LIMIT        = 16;   // Cycles allowed for one handshake phase
	localparam int HALT_LIMIT      = 1000;
	localparam int CYCLES_PER_TEST = 2000;

	logic     clk;
	logic     rst;
	logic     run;
	logic     halt;
	logic     load_req;
	pc_t      load_addr;
	word_t    load_data;
	logic     load_ack;
	logic     dbg_req;
	reg_idx_t dbg_reg;
	word_t    dbg_data;
	logic     dbg_ack;

	logic [255:0] test_name [$];
	int           prog_test [$]; // Owning test of each program word
	pc_t          prog_addr [$];
	word_t        prog_word [$];
	int           exp_test [$];
	reg_idx_t     exp_reg [$];
	word_t        exp_val [$];

	int   num_tests;
	int   mismatch_count;
	int   proto_count;
	int   file_count;
	int   sva_count;
	int   total_errors;
	logic parsed;

	wisc_core i_wisc_core (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.halt      (halt),
		.load_req  (load_req),
		.load_addr (load_addr),
		.load_data (load_data),
		.load_ack  (load_ack),
		.dbg_req   (dbg_req),
		.dbg_reg   (dbg_reg),
		.dbg_data  (dbg_data),
		.dbg_ack   (dbg_ack)
	);

	bind wisc_core wisc_core_sva i_wisc_core_sva (
		.clk      (clk),
		.rst      (rst),
		.run      (run),
		.halt     (halt),
		.load_req (load_req),
		.load_ack (load_ack),
		.dbg_req  (dbg_req),
		.dbg_ack  (dbg_ack)
	);

	always #CLK_HALF clk = ~clk;

	task automatic check_word(input reg_idx_t r, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: R%0d = %h, expected %h", $time, r, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %0s = %b, expected %b", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic reset_core();
		run = 1'b0;
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	// Four-phase master on the load port
	task automatic load_instruction(input pc_t addr, input word_t data);
		int n;
		load_addr = addr;
		load_data = data;
		load_req  = 1'b1;
		n = 0;
		while (!load_ack && n < HS_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!load_ack) begin
			$display("ERROR: load of address %h was never acknowledged", addr);
			proto_count++;
		end else if (n != 1) begin
			$display("ERROR: load_ack came %0d cycles after load_req instead of 1", n);
			proto_count++;
		end
		load_req = 1'b0;
		n = 0;
		while (load_ack && n < HS_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (load_ack) begin
			$display("ERROR: load_ack stayed high after load_req was released");
			proto_count++;
		end
	endtask

	task automatic read_register(input reg_idx_t r, output word_t value);
		int n;
		dbg_reg = r;
		dbg_req = 1'b1;
		value   = '0;
		n = 0;
		while (!dbg_ack && n < HS_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!dbg_ack) begin
			$display("ERROR: debug read of R%0d was never acknowledged", r);
			proto_count++;
		end else begin
			value = dbg_data; // Valid while dbg_ack is high
			if (n != 1) begin
				$display("ERROR: dbg_ack came %0d cycles after dbg_req instead of 1", n);
				proto_count++;
			end
		end
		dbg_req = 1'b0;
		n = 0;
		while (dbg_ack && n < HS_LIMIT) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (dbg_ack) begin
			$display("ERROR: dbg_ack stayed high after dbg_req was released");
			proto_count++;
		end
	endtask

	task automatic read_tests();
		int            fd;
		int            code;
		int            cur;
		logic [255:0]  tok;
		logic [255:0]  name;
		logic [1023:0] line;
		logic [15:0]   a;
		logic [15:0]   v;
		fd = $fopen("wisc_tests.txt", "r");
		if (fd == 0) begin
			$display("ERROR: could not open wisc_tests.txt for reading");
			file_count++;
		end else begin
			cur  = -1;
			code = $fscanf(fd, "%s", tok);
			while (code == 1) begin
				if (tok == 256'("#")) begin
					code = $fgets(line, fd);
				end else if (tok == 256'("T")) begin
					code = $fscanf(fd, "%s", name);
					test_name.push_back(name);
					cur = test_name.size() - 1;
				end else if (tok == 256'("P") && cur >= 0) begin
					code = $fscanf(fd, "%h %h", a, v);
					if (code != 2) begin
						$display("ERROR: incomplete P line in wisc_tests.txt");
						file_count++;
					end
					prog_test.push_back(cur);
					prog_addr.push_back(a[7:0]);
					prog_word.push_back(v);
				end else if (tok == 256'("E") && cur >= 0) begin
					code = $fscanf(fd, "%h %h", a, v);
					if (code != 2) begin
						$display("ERROR: incomplete E line in wisc_tests.txt");
						file_count++;
					end
					exp_test.push_back(cur);
					exp_reg.push_back(a[3:0]);
					exp_val.push_back(v);
				end else if (tok == 256'("END")) begin
					cur = -1;
				end else begin
					$display("ERROR: unexpected token %0s in wisc_tests.txt", tok);
					file_count++;
				end
				code = $fscanf(fd, "%s", tok);
			end
			$fclose(fd);
		end
		num_tests = test_name.size();
	endtask

	task automatic run_test(input int t);
		int    cycles;
		word_t got;
		$display("Test %0d: %0s", t + 1, test_name[t]);
		reset_core();
		for (int i = 0; i < prog_test.size(); i++) begin
			if (prog_test[i] == t) begin
				load_instruction(prog_addr[i], prog_word[i]);
			end
		end
		check_flag("halt", halt, 1'b0); // Not yet started
		run    = 1'b1;
		cycles = 0;
		while (!halt && cycles < HALT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!halt) begin
			$display("ERROR: test %0s did not raise halt within %0d cycles", test_name[t],
				HALT_LIMIT);
			proto_count++;
		end
		for (int i = 0; i < exp_test.size(); i++) begin
			if (exp_test[i] == t) begin
				read_register(exp_reg[i], got);
				check_word(exp_reg[i], got, exp_val[i]);
			end
		end
		check_flag("halt", halt, 1'b1);
		run = 1'b0;
		@(posedge clk);
		#2;
		check_flag("halt", halt, 1'b0); // Cleared once run is low
	endtask

	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		run            = 1'b0;
		load_req       = 1'b0;
		load_addr      = '0;
		load_data      = '0;
		dbg_req        = 1'b0;
		dbg_reg        = '0;
		parsed         = 1'b0;
		num_tests      = 0;
		mismatch_count = 0;
		proto_count    = 0;
		file_count     = 0;
		sva_count      = 0;
		read_tests();
		if (num_tests == 0) begin
			$display("ERROR: no tests were found in wisc_tests.txt");
			file_count++;
		end
		parsed = 1'b1;
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		sva_count    = i_wisc_core.i_wisc_core_sva.fail_count;
		total_errors = mismatch_count + proto_count + file_count + sva_count;
		$display("Errors: %0d mismatches, %0d protocol, %0d file, %0d assertion, %0d tests run",
			mismatch_count, proto_count, file_count, sva_count, num_tests);
		if (total_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Watchdog scaled to the number of tests
	initial begin
		wait (parsed);
		repeat (num_tests * CYCLES_PER_TEST + 100) @(posedge clk);
		$display("ERROR: watchdog expired, %0d tests did not finish within %0d clock cycles",
			num_tests, num_tests * CYCLES_PER_TEST + 100);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* wisc_core.sv */
// Top level of the five-stage core, joining the four stages; the DUT of the testbench
`timescale 1ns/1ps
`default_nettype none

module wisc_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               run,
	output logic               halt,
	input  logic               load_req,
	input  wisc_pkg::pc_t      load_addr,
	input  wisc_pkg::word_t    load_data,
	output logic               load_ack,
	input  logic               dbg_req,
	input  wisc_pkg::reg_idx_t dbg_reg,
	output wisc_pkg::word_t    dbg_data,
	output logic               dbg_ack
);
	import wisc_pkg::*;

	word_t instr;       // Fetch/decode register
	logic  instr_valid;
	logic  stall;
	logic  halting;     // HLT accepted, fetch frozen

	id_ex_ifc  i_id_ex ();
	ex_mem_ifc i_ex_mem ();
	mem_wb_ifc i_mem_wb ();

	fetch_stage i_fetch_stage (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.stall       (stall),
		.halting     (halting),
		.load_req    (load_req),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_ack    (load_ack),
		.instr       (instr),
		.instr_valid (instr_valid)
	);

	decode_stage i_decode_stage (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.halting     (halting),
		.dbg_req     (dbg_req),
		.dbg_reg     (dbg_reg),
		.dbg_data    (dbg_data),
		.dbg_ack     (dbg_ack),
		.id_ex       (i_id_ex),
		.ex_mem      (i_ex_mem),
		.mem_wb      (i_mem_wb)
	);

	execute_stage i_execute_stage (
		.clk    (clk),
		.rst    (rst),
		.id_ex  (i_id_ex),
		.ex_mem (i_ex_mem)
	);

	memory_stage i_memory_stage (
		.clk    (clk),
		.rst    (rst),
		.ex_mem (i_ex_mem),
		.mem_wb (i_mem_wb),
		.halt   (halt),
		.run    (run)
	);

endmodule

`default_nettype wire

/* wisc_core_sva.sv */
// Handshake, reset and halt assertions for wisc_core, attached to the core by bind in the testbench
`timescale 1ns/1ps
`default_nettype none

module wisc_core_sva (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halt,
	input logic load_req,
	input logic load_ack,
	input logic dbg_req,
	input logic dbg_ack
);
	int fail_count = 0; // Count of failed assertions

	a_load_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(load_ack) |-> $past(load_req))
	else begin
		$error("load_ack rose without load_req");
		fail_count++;
	end

	a_load_ack_hold: assert property (@(posedge clk) disable iff (rst)
		(load_ack && load_req) |=> load_ack)
	else begin
		$error("load_ack fell while load_req was high");
		fail_count++;
	end

	a_dbg_ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(dbg_ack) |-> $past(dbg_req))
	else begin
		$error("dbg_ack rose without dbg_req");
		fail_count++;
	end

	a_dbg_ack_hold: assert property (@(posedge clk) disable iff (rst)
		(dbg_ack && dbg_req) |=> dbg_ack)
	else begin
		$error("dbg_ack fell while dbg_req was high");
		fail_count++;
	end

	// Outputs cleared one cycle into reset
	a_reset_clear: assert property (@(posedge clk)
		rst |=> (!halt && !load_ack && !dbg_ack))
	else begin
		$error("halt or an ack still high after reset");
		fail_count++;
	end

	a_halt_hold: assert property (@(posedge clk) disable iff (rst)
		(halt && run) |=> halt)
	else begin
		$error("halt fell while run stayed high");
		fail_count++;
	end

endmodule

`default_nettype wire

/* wisc_pkg.sv */
// Shared types, opcodes and memory depths for the pipelined 16-bit core, imported by every RTL unit
`default_nettype none

package wisc_pkg;

	typedef logic [15:0] word_t;    // Data word and instruction word
	typedef logic [7:0]  pc_t;      // Instruction memory address
	typedef logic [7:0]  daddr_t;   // Data memory address
	typedef logic [3:0]  reg_idx_t; // Register number

	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int NUM_REGS   = 16;

	// Bits 15:12 of every instruction
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_NOR = 4'd3,
		OP_SLL = 4'd4,
		OP_SRL = 4'd5,
		OP_SRA = 4'd6,
		OP_LW  = 4'd8,
		OP_SW  = 4'd9,
		OP_LHB = 4'd10,
		OP_LLB = 4'd11,
		OP_HLT = 4'd15
	} opcode_t;

	// Codes 0 to 6 follow the opcode order so decode can copy opcode bits
	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_NOR   = 3'd3,
		ALU_SLL   = 3'd4,
		ALU_SRL   = 3'd5,
		ALU_SRA   = 3'd6,
		ALU_PASSB = 3'd7  // B, with the low byte of A merged in for LHB
	} alu_op_t;

	localparam word_t NOP_WORD = 16'h7000; // Opcode 7 is unused and writes nothing

endpackage

`default_nettype wire

/* wisc_tests.txt */
# Columns: T <test name> / P <imem address hex> <instruction hex> / E <register hex> <value hex> / END
# Expected values are worked out by hand from the instruction semantics
T arith_logic
P 00 B134
P 01 A112
P 02 B2F0
P 03 A20F
P 04 0312
P 05 1412
P 06 2512
P 07 3612
P 08 B7FF
P 09 B802
P 0A 0978
P 0B 1A87
P 0C BB80
P 0D AB80
P 0E 1C0B
P 0F F000
E 0 0000
E 1 1234
E 2 0FF0
E 3 2224
E 4 0244
E 5 0230
E 6 E00B
E 7 FFFF
E 8 0002
E 9 0001
E A 0003
E B 8080
E C 7F80
E D 0000
END
T shifts
P 00 B181
P 01 A180
P 02 B231
P 03 A240
P 04 4310
P 05 4411
P 06 452F
P 07 5611
P 08 571F
P 09 6811
P 0A 691F
P 0B 6A21
P 0C 6B2F
P 0D 6C10
P 0E 5D20
P 0F F000
E 1 8081
E 2 4031
E 3 8081
E 4 0102
E 5 8000
E 6 4040
E 7 0001
E 8 C040
E 9 FFFF
E A 2018
E B 0000
E C 8081
E D 4031
E E 0000
END
T immediate_loads
P 00 B17F
P 01 B280
P 02 A212
P 03 A234
P 04 B300
P 05 A3AB
P 06 A4CD
P 07 B401
P 08 F000
E 1 007F
E 2 3480
E 3 AB00
E 4 0001
E 5 0000
E 9 0000
END
T memory
P 00 B866
P 01 B120
P 02 B2A5
P 03 A25A
P 04 B311
P 05 9213
P 06 931E
P 07 8413
P 08 851E
P 09 B622
P 0A 8761
P 0B 896C
P 0C F000
E 1 0020
E 2 5AA5
E 3 0011
E 4 5AA5
E 5 0011
E 6 0022
E 7 5AA5
E 8 0066
E 9 0011
E A 0000
END
T chain_back_to_back
P 00 B103
P 01 0211
P 02 4322
P 03 1431
P 04 3542
P 05 6653
P 06 2764
P 07 F000
E 1 0003
E 2 0006
E 3 0018
E 4 0015
E 5 FFE8
E 6 FFFD
E 7 0015
E 8 0000
END
T chain_with_gaps
P 00 B103
P 01 7000
P 02 7000
P 03 0211
P 04 7000
P 05 7000
P 06 4322
P 07 7000
P 08 7000
P 09 1431
P 0A 7000
P 0B 7000
P 0C 3542
P 0D 7000
P 0E 7000
P 0F 6653
P 10 7000
P 11 7000
P 12 2764
P 13 F000
E 1 0003
E 2 0006
E 3 0018
E 4 0015
E 5 FFE8
E 6 FFFD
E 7 0015
E 8 0000
END
